// ==== verif/mc_testdata.txt ====
// Program words from 0x00. At 0x40 the program length and the number of checks,
// then one check per line: switch setting, expected display word
@00
00500093 // addi x1, x0, 5
00700113 // addi x2, x0, 7
002081B3 // add  x3, x1, x2
40110233 // sub  x4, x2, x1
123452B7 // lui  x5, 0x12345
00900013 // addi x0, x0, 9
00208463 // beq  x1, x2, +8 (not taken)
00108463 // beq  x1, x1, +8 (taken)
00100313 // addi x6, x0, 1 (skipped)
008003EF // jal  x7, +8
00300413 // addi x8, x0, 3 (skipped)
005184B3 // add  x9, x3, x5
0000006F // jal  x0, 0 (halt)
@40
0000000D
0000000B
00000007 00000000 // x0
00000017 00000005 // x1
00000027 00000007 // x2
00000037 0000000C // x3
00000047 00000002 // x4
00000057 12345000 // x5
00000067 00000000 // x6
00000077 00000028 // x7 link
00000087 00000000 // x8
00000097 1234500C // x9
000000A7 00000000 // x10

// ==== project.f ====
+incdir+common
common/mc_pkg.sv
common/core_ctrl_if.sv
logic/step_timer.sv
logic/phase_fsm.sv
datapath/core_datapath.sv
display/debug_display.sv
logic/mc_top.sv
verif/mc_tb.sv

// ==== Bender.yml ====
package:
  name: mc_core

sources:
  - include_dirs:
      - common
    files:
      - common/mc_pkg.sv
      - common/core_ctrl_if.sv
      - logic/step_timer.sv
      - logic/phase_fsm.sv
      - datapath/core_datapath.sv
      - display/debug_display.sv
      - logic/mc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/mc_tb.sv

// ==== verif/mc_tb.sv ====
`include "mc_defs.svh"

module mc_tb import mc_pkg::*; ();

	localparam int RUN_TIMEOUT = 64 * 4 * `STEP_DIV_SLOW;
	localparam int NUM_RANDOM  = 8;

	logic        clk;
	logic        rstn;
	logic [15:0] sw;
	word_t       instr;
	word_t       pc;
	word_t       disp_data;
	logic [7:0]  disp_seg;
	logic [7:0]  disp_an;

	word_t       data_mem [128];	// Program at 0x00 and check records at 0x40
	int          prog_len;
	int          check_cnt;
	word_t       halt_pc;
	int          mismatch_cnt;
	int          fail_cnt;
	logic        timed_out;
	int          rnd;

	logic [7:0]  last_an;
	logic        scan_seen;
	int          scan_cycles;
	int          low_cnt;
	int          scan_digit;

	mc_top i_dut (
		.clk         (clk),
		.rstn        (rstn),
		.sw_i        (sw),
		.instr_i     (instr),
		.pc_o        (pc),
		.disp_data_o (disp_data),
		.disp_seg_o  (disp_seg),
		.disp_an_o   (disp_an)
	);

	// Program memory answering the PC without delay and NOP beyond the program
	assign instr = (pc[31:2] < prog_len) ? data_mem[pc[7:2]] : 32'h0000_0013;

	always #2 clk = ~clk;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_seg(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		fail_cnt++;
		$display("%s", msg);
	endtask

	// Active-low pattern {dp,g,f,e,d,c,b,a} of a hex digit
	function automatic logic [7:0] hex_segments(input logic [3:0] value);
		logic [6:0] lit;
		case (value)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1101111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100;
			4'hC: lit = 7'b0111001;
			4'hD: lit = 7'b1011110;
			4'hE: lit = 7'b1111001;
			default: lit = 7'b1110001;
		endcase
		return {1'b1, ~lit};
	endfunction

	// Scanner watch on the falling edge
	always @(negedge clk) begin
		if (!rstn) begin
			scan_seen   = 1'b0;
			scan_cycles = 0;
			last_an     = 8'hFE;
		end else begin
			scan_cycles++;
			low_cnt = 0;
			for (int i = 0; i < 8; i++) begin
				if (!disp_an[i]) begin
					low_cnt++;
					scan_digit = i;
				end
			end
			if (low_cnt != 1) begin
				report_failure($sformatf("anode output %h does not select exactly one digit",
					disp_an));
			end else begin
				check_seg("disp_seg_o", disp_seg, hex_segments(disp_data[scan_digit*4 +: 4]));
				if (disp_an != last_an) begin
					if (disp_an != {last_an[6:0], last_an[7]}) begin
						report_failure("the scanned digit did not advance by one");
					end
					if (scan_seen && scan_cycles != `SCAN_DIV) begin
						report_failure($sformatf("digit was held %0d cycles instead of %0d",
							scan_cycles, `SCAN_DIV));
					end
					scan_seen   = 1'b1;
					scan_cycles = 0;
					last_an     = disp_an;
				end
			end
		end
	end

	// Reset the core and run it until the PC rests on the halt JAL
	task automatic run_program(input logic slow, input int div);
		word_t last_pc;
		int    since;
		int    changes;
		int    stable;
		int    cycles;
		@(posedge clk);
		rstn <= 1'b0;
		sw   <= {slow, 15'h0};
		repeat (4) @(posedge clk);
		rstn    <= 1'b1;
		last_pc = `RESET_PC;
		since   = 0;
		changes = 0;
		stable  = 0;
		cycles  = 0;
		while (stable < 4 * div && cycles < RUN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			since++;
			if (pc != last_pc) begin
				if (changes > 0 && since != 4 * div) begin	// First one may run at the old rate
					report_failure($sformatf("pc_o changed after %0d cycles, expected %0d",
						since, 4 * div));
				end
				changes++;
				since   = 0;
				last_pc = pc;
			end
			if (pc == halt_pc) begin
				stable++;
			end else begin
				stable = 0;
			end
		end
		if (stable < 4 * div) begin
			timed_out = 1'b1;
			report_failure($sformatf("program did not reach the halt address %h in time",
				halt_pc));
		end
	endtask

	task automatic check_registers();
		logic [15:0] sw_val;
		for (int i = 0; i < check_cnt; i++) begin
			sw_val = data_mem[66 + 2*i][15:0];
			@(posedge clk);
			sw <= sw_val;
			@(negedge clk);
			check_word($sformatf("disp_data_o (sw %h)", sw_val), disp_data,
				data_mem[67 + 2*i]);
		end
	endtask

	task automatic check_display();
		logic [15:0] sw_val;
		word_t       cur;
		cur = data_mem[halt_pc[7:2]];
		@(posedge clk);
		sw <= 16'h0000;
		@(negedge clk);
		check_word("disp_data_o (instruction)", disp_data, cur);
		@(posedge clk);
		sw <= 16'h0001;
		@(negedge clk);
		check_word("disp_data_o (pc)", disp_data, halt_pc);
		@(posedge clk);
		sw <= 16'h0002;
		@(negedge clk);
		check_idx("disp_data_o (rs1 index)", disp_data[4:0], cur[19:15]);
		@(posedge clk);
		sw <= 16'h0004;
		@(negedge clk);
		check_idx("disp_data_o (rs2 index)", disp_data[4:0], cur[24:20]);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd    = $urandom;
			sw_val = {rnd[15:4], 1'b1, rnd[2:0]};	// Codes 8 to 15
			@(posedge clk);
			sw <= sw_val;
			@(negedge clk);
			check_word($sformatf("disp_data_o (sw %h)", sw_val), disp_data, {16'h0, sw_val});
		end
	endtask

	initial begin
		clk          = 1'b0;
		rstn         = 1'b0;
		sw           = 16'h0000;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		timed_out    = 1'b0;
		rnd          = $urandom(30187);
		$readmemh("verif/mc_testdata.txt", data_mem);
		prog_len  = data_mem[64];
		check_cnt = data_mem[65];
		halt_pc   = (prog_len - 1) * 4;	// Last word is the self-loop JAL

		run_program(1'b0, `STEP_DIV_FAST);
		if (!timed_out) begin
			check_registers();
			check_display();
			run_program(1'b1, `STEP_DIV_SLOW);
			if (!timed_out) begin
				check_registers();
			end
		end

		$display("run finished: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/mc_top.sv ====
module mc_top import mc_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic [15:0] sw_i,
	input  word_t       instr_i,
	output word_t       pc_o,
	output word_t       disp_data_o,
	output logic [7:0]  disp_seg_o,
	output logic [7:0]  disp_an_o
);

	logic     step;
	word_t    instr;
	word_t    alu;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    reg_val;
	reg_idx_t rs1;
	reg_idx_t rs2;

	core_ctrl_if ctrl ();

	step_timer i_step_timer (
		.clk    (clk),
		.rstn   (rstn),
		.slow_i (sw_i[15]),	// Slow stepping
		.step_o (step)
	);

	phase_fsm i_phase_fsm (
		.clk    (clk),
		.rstn   (rstn),
		.step_i (step),
		.ctrl   (ctrl.phase_fsm)
	);

	core_datapath i_core_datapath (
		.clk       (clk),
		.rstn      (rstn),
		.ctrl      (ctrl.datapath),
		.instr_i   (instr_i),
		.rd_sel_i  (sw_i[8:4]),
		.pc_o      (pc_o),
		.instr_o   (instr),
		.alu_o     (alu),
		.rs1_val_o (rs1_val),
		.rs2_val_o (rs2_val),
		.reg_val_o (reg_val),
		.rs1_o     (rs1),
		.rs2_o     (rs2)
	);

	debug_display i_debug_display (
		.clk         (clk),
		.rstn        (rstn),
		.sw_i        (sw_i),
		.instr_i     (instr),
		.pc_i        (pc_o),
		.alu_i       (alu),
		.rs1_val_i   (rs1_val),
		.rs2_val_i   (rs2_val),
		.reg_val_i   (reg_val),
		.rs1_i       (rs1),
		.rs2_i       (rs2),
		.disp_data_o (disp_data_o),
		.disp_seg_o  (disp_seg_o),
		.disp_an_o   (disp_an_o)
	);

endmodule

// ==== display/debug_display.sv ====
`include "mc_defs.svh"

module debug_display import mc_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic [15:0] sw_i,
	input  word_t       instr_i,
	input  word_t       pc_i,
	input  word_t       alu_i,
	input  word_t       rs1_val_i,
	input  word_t       rs2_val_i,
	input  word_t       reg_val_i,
	input  reg_idx_t    rs1_i,
	input  reg_idx_t    rs2_i,
	output word_t       disp_data_o,
	output logic [7:0]  disp_seg_o,
	output logic [7:0]  disp_an_o
);

	localparam int SCAN_W = $clog2(`SCAN_DIV);

	disp_sel_t         sel;
	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        digit;
	logic [3:0]        nibble;

	assign sel = sw_i[3:0];

	always_comb begin
		case (sel)
			4'd0:    disp_data_o = instr_i;
			4'd1:    disp_data_o = pc_i;
			4'd2:    disp_data_o = {27'b0, rs1_i};
			4'd3:    disp_data_o = rs1_val_i;
			4'd4:    disp_data_o = {27'b0, rs2_i};
			4'd5:    disp_data_o = rs2_val_i;
			4'd6:    disp_data_o = alu_i;
			4'd7:    disp_data_o = reg_val_i;	// Register from sw[8:4]
			default: disp_data_o = {16'b0, sw_i};
		endcase
	end

	always_ff @(posedge clk, negedge rstn) begin
		if (!rstn) begin
			scan_cnt <= '0;
			digit    <= '0;
		end else if (scan_cnt == SCAN_W'(`SCAN_DIV - 1)) begin
			scan_cnt <= '0;
			digit    <= digit + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign disp_an_o = ~(8'b1 << digit);	// Active low
	assign nibble    = disp_data_o[digit*4 +: 4];

	// Segments {dp,g,f,e,d,c,b,a}, active low
	always_comb begin
		case (nibble)
			4'h0:    disp_seg_o = 8'hC0;
			4'h1:    disp_seg_o = 8'hF9;
			4'h2:    disp_seg_o = 8'hA4;
			4'h3:    disp_seg_o = 8'hB0;
			4'h4:    disp_seg_o = 8'h99;
			4'h5:    disp_seg_o = 8'h92;
			4'h6:    disp_seg_o = 8'h82;
			4'h7:    disp_seg_o = 8'hF8;
			4'h8:    disp_seg_o = 8'h80;
			4'h9:    disp_seg_o = 8'h90;
			4'hA:    disp_seg_o = 8'h88;
			4'hB:    disp_seg_o = 8'h83;
			4'hC:    disp_seg_o = 8'hC6;
			4'hD:    disp_seg_o = 8'hA1;
			4'hE:    disp_seg_o = 8'h86;
			default: disp_seg_o = 8'h8E;
		endcase
	end

endmodule

// ==== datapath/core_datapath.sv ====
`include "mc_defs.svh"

module core_datapath import mc_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	core_ctrl_if.datapath     ctrl,
	input  word_t             instr_i,
	input  reg_idx_t          rd_sel_i,
	output word_t             pc_o,
	output word_t             instr_o,
	output word_t             alu_o,
	output word_t             rs1_val_o,
	output word_t             rs2_val_o,
	output word_t             reg_val_o,
	output reg_idx_t          rs1_o,
	output reg_idx_t          rs2_o
);

	word_t    pc;
	word_t    ir;
	word_t    rf [32];
	word_t    op_a;	// Operands latched in DECODE
	word_t    op_b;
	word_t    imm_q;
	word_t    imm;
	word_t    alu_b;
	word_t    alu_res;
	word_t    alu_q;
	word_t    target_q;
	opcode_t  opcode;
	reg_idx_t rd;
	alu_op_t  alu_op;
	logic     rd_write;

	assign opcode = ir[6:0];
	assign rd     = ir[11:7];
	assign rs1_o  = ir[19:15];
	assign rs2_o  = ir[24:20];

	// Immediate by format
	always_comb begin
		case (opcode)
			`OPC_LUI:    imm = {ir[31:12], 12'b0};
			`OPC_BRANCH: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			`OPC_JAL:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			default:     imm = {{20{ir[31]}}, ir[31:20]};	// I type
		endcase
	end

	always_comb begin
		alu_b    = op_b;
		rd_write = 1'b1;
		case (opcode)
			`OPC_OP:    alu_op = ir[30] ? ALU_SUB : ALU_ADD;
			`OPC_OPIMM: begin
				alu_op = ALU_ADD;
				alu_b  = imm_q;
			end
			`OPC_LUI: begin
				alu_op = ALU_PASS_B;
				alu_b  = imm_q;
			end
			`OPC_JAL:   alu_op = ALU_LINK;
			default: begin
				alu_op   = ALU_SUB;	// BEQ compare
				rd_write = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD:    alu_res = op_a + alu_b;
			ALU_SUB:    alu_res = op_a - alu_b;
			ALU_PASS_B: alu_res = alu_b;
			default:    alu_res = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk, negedge rstn) begin
		if (!rstn) begin
			pc                <= `RESET_PC;
			ir                <= '0;
			ctrl.branch_taken <= 1'b0;
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else begin
			if (ctrl.fetch_en) begin
				ir <= instr_i;
			end
			if (ctrl.exec_en) begin
				ctrl.branch_taken <= (opcode == `OPC_JAL) ||
					((opcode == `OPC_BRANCH) && (ir[14:12] == 3'b000) && (alu_res == '0));
			end
			if (ctrl.wb_en) begin
				if (rd_write && rd != '0) begin
					rf[rd] <= alu_q;
				end
				pc <= ctrl.branch_taken ? target_q : pc + 32'd4;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (ctrl.decode_en) begin
			op_a  <= rf[rs1_o];
			op_b  <= rf[rs2_o];
			imm_q <= imm;
		end
		if (ctrl.exec_en) begin
			alu_q    <= alu_res;
			target_q <= pc + imm_q;
		end
	end

	assign pc_o      = pc;
	assign instr_o   = ir;
	assign alu_o     = alu_q;
	assign rs1_val_o = op_a;
	assign rs2_val_o = op_b;
	assign reg_val_o = rf[rd_sel_i];

	a_x0_zero: assert property (@(posedge clk) disable iff (!rstn)
		(rd_sel_i == '0) |-> (reg_val_o == '0));

endmodule

// ==== logic/phase_fsm.sv ====
module phase_fsm import mc_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	input  logic              step_i,
	core_ctrl_if.phase_fsm    ctrl
);

	phase_t state;
	phase_t state_next;

	always_comb begin
		case (state)
			FETCH:   state_next = DECODE;
			DECODE:  state_next = EXEC;
			EXEC:    state_next = WB;
			default: state_next = FETCH;
		endcase
	end

	always_ff @(posedge clk, negedge rstn) begin
		if (!rstn) begin
			state <= FETCH;
		end else if (step_i) begin
			state <= state_next;
		end
	end

	// Step strobe routed to the current phase
	assign ctrl.fetch_en  = step_i && (state == FETCH);
	assign ctrl.decode_en = step_i && (state == DECODE);
	assign ctrl.exec_en   = step_i && (state == EXEC);
	assign ctrl.wb_en     = step_i && (state == WB);

	a_en_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0({ctrl.fetch_en, ctrl.decode_en, ctrl.exec_en, ctrl.wb_en}));

	a_en_on_step: assert property (@(posedge clk) disable iff (!rstn)
		(ctrl.fetch_en || ctrl.decode_en || ctrl.exec_en || ctrl.wb_en) |-> step_i);

endmodule

// ==== logic/step_timer.sv ====
`include "mc_defs.svh"

module step_timer (
	input  logic clk,
	input  logic rstn,
	input  logic slow_i,
	output logic step_o
);

	localparam int CNT_W = $clog2(`STEP_DIV_SLOW);

	logic [CNT_W-1:0] cnt;
	logic             slow_q;	// Rate in use for this period
	logic [CNT_W-1:0] last;

	assign last = slow_q ? CNT_W'(`STEP_DIV_SLOW - 1) : CNT_W'(`STEP_DIV_FAST - 1);

	always_ff @(posedge clk, negedge rstn) begin
		if (!rstn) begin
			cnt    <= '0;
			slow_q <= 1'b0;
			step_o <= 1'b0;
		end else if (cnt == last) begin
			cnt    <= '0;
			slow_q <= slow_i;	// New rate from the next period
			step_o <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			step_o <= 1'b0;
		end
	end

	a_step_single: assert property (@(posedge clk) disable iff (!rstn)
		step_o |=> !step_o);

endmodule

// ==== common/core_ctrl_if.sv ====
interface core_ctrl_if;

	logic fetch_en;
	logic decode_en;
	logic exec_en;
	logic wb_en;
	logic branch_taken;	// PC redirect decided in EXEC

	modport phase_fsm (
		output fetch_en,
		output decode_en,
		output exec_en,
		output wb_en,
		input  branch_taken
	);

	modport datapath (
		input  fetch_en,
		input  decode_en,
		input  exec_en,
		input  wb_en,
		output branch_taken
	);

endinterface

// ==== common/mc_pkg.sv ====
package mc_pkg;

	typedef logic [31:0] word_t;	// Data, instruction or address
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [3:0]  disp_sel_t;	// Display code from sw[3:0]

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B,	// LUI
		ALU_LINK	// JAL return address
	} alu_op_t;

	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXEC,
		WB
	} phase_t;

endpackage

// ==== common/mc_defs.svh ====
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// Clock cycles per step
`define STEP_DIV_FAST 8
`define STEP_DIV_SLOW 32

// Clock cycles per display digit
`define SCAN_DIV 4

`define RESET_PC 32'h0000_0000

`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`endif
